/* src.f */
npc_pkg.sv
npc_fetch.sv
npc_decode.sv
npc_regfile.sv
npc_alu.sv
npc_lsu.sv
npc.sv
tb_npc.sv

/* run.sh */
#!/bin/sh
# compile and run the npc testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_npc -o sim_npc
./obj_dir/sim_npc > sim.log 2>&1 || true
cat sim.log
if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
exit 1

/* tb_npc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_npc
    import npc_pkg::*;
();

    localparam int reset_cycles = 16;
    localparam int halt_cycles  = 8;
    localparam int max_words    = 64;

    logic       clk;
    logic       reset;
    logic       load_en;
    imem_addr_t load_addr;
    inst_t      load_data;
    xlen_t      pc;
    logic       halted;
    logic       retire_en;
    reg_idx_t   retire_rd;
    xlen_t      retire_data;
    logic       store_en;
    xlen_t      store_addr;
    xlen_t      store_data;
    logic [3:0] store_mask;

    // program image and expected trace, one entry per executed instruction
    inst_t      prog [max_words];
    xlen_t      exp_pc [max_words];
    logic       exp_en [max_words];
    reg_idx_t   exp_rd [max_words];
    xlen_t      exp_val [max_words];
    // expected stores in program order
    xlen_t      st_addr [8];
    xlen_t      st_data [8];
    logic [3:0] st_mask [8];
    // shadow registers for the expected values
    xlen_t      xr [32];
    int         n_prog;
    int         n_cyc;
    int         n_store;
    int         n_seen;
    int         errors;
    int         checks;
    logic       tables_ready;

    npc dut (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .pc(pc), .halted(halted), .retire_en(retire_en),
        .retire_rd(retire_rd), .retire_data(retire_data), .store_en(store_en),
        .store_addr(store_addr), .store_data(store_data), .store_mask(store_mask)
    );

    always #2 clk = ~clk;

    // plain lcg, immediates come from bits 27:16
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic xlen_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // unsigned less-than as a 0/1 word
    function automatic xlen_t ult(input xlen_t a, input xlen_t b);
        return (a < b) ? 32'd1 : 32'd0;
    endfunction

    // one bit at a time, sign bit copied in from the left
    function automatic xlen_t sra(input xlen_t v, input int sh);
        xlen_t r;
        int    i;
        r = v;
        for (i = 0; i < sh; i++) begin
            r = {r[31], r[31:1]};
        end
        return r;
    endfunction

    // instruction encoders, one per format
    function automatic inst_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1,
                                    input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic inst_t enc_s(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic inst_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic inst_t enc_u(input logic [6:0] op, input reg_idx_t rd,
                                    input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic inst_t enc_j(input reg_idx_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // address of the next word placed in the program
    function automatic xlen_t prog_addr();
        return reset_vector + xlen_t'(4 * n_prog);
    endfunction

    // executed instruction, also a row of the expected trace
    task automatic emit(input inst_t w, input logic wr, input reg_idx_t rd, input xlen_t val);
        prog[n_prog]   = w;
        exp_pc[n_cyc]  = prog_addr();
        exp_en[n_cyc]  = wr && (rd != '0);
        exp_rd[n_cyc]  = rd;
        exp_val[n_cyc] = val;
        if (wr && (rd != '0)) begin
            xr[rd] = val;
        end
        n_prog++;
        n_cyc++;
    endtask

    // jumped over, never shows up in the trace
    task automatic skip(input inst_t w);
        prog[n_prog] = w;
        n_prog++;
    endtask

    task automatic add_store(input xlen_t addr, input xlen_t data, input logic [3:0] mask);
        st_addr[n_store] = addr;
        st_data[n_store] = data;
        st_mask[n_store] = mask;
        n_store++;
    endtask

    task automatic build_program();
        logic [31:0] seed;
        logic [11:0] rnd;
        xlen_t       here;
        xlen_t       word;
        int          i;
        seed    = 32'd32712;
        n_prog  = 0;
        n_cyc   = 0;
        n_store = 0;
        for (i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        // random operands in x1..x6
        for (i = 0; i < 6; i++) begin
            seed = lcg_next(seed);
            rnd  = seed[27:16];
            emit(enc_i(op_imm, 3'b000, reg_idx_t'(i + 1), 5'd0, rnd), 1'b1,
                 reg_idx_t'(i + 1), sext12(rnd));
        end
        emit(enc_r(7'h00, 3'b000, 5'd7, 5'd1, 5'd2), 1'b1, 5'd7, xr[1] + xr[2]);
        emit(enc_r(7'h20, 3'b000, 5'd8, 5'd1, 5'd2), 1'b1, 5'd8, xr[1] - xr[2]);
        emit(enc_r(7'h00, 3'b100, 5'd9, 5'd3, 5'd4), 1'b1, 5'd9, xr[3] ^ xr[4]);
        emit(enc_r(7'h00, 3'b110, 5'd10, 5'd5, 5'd6), 1'b1, 5'd10, xr[5] | xr[6]);
        emit(enc_r(7'h00, 3'b011, 5'd11, 5'd1, 5'd2), 1'b1, 5'd11, ult(xr[1], xr[2]));
        emit(enc_i(op_imm, 3'b011, 5'd12, 5'd3, 12'h400), 1'b1, 5'd12,
             ult(xr[3], sext12(12'h400)));
        // negative operand for srai, -100
        emit(enc_i(op_imm, 3'b000, 5'd13, 5'd0, 12'hf9c), 1'b1, 5'd13, sext12(12'hf9c));
        emit(enc_i(op_imm, 3'b101, 5'd14, 5'd13, {7'h20, 5'd3}), 1'b1, 5'd14, sra(xr[13], 3));
        emit(enc_i(op_imm, 3'b101, 5'd15, 5'd7, {7'h20, 5'd5}), 1'b1, 5'd15, sra(xr[7], 5));
        // write to x0, no retire
        emit(enc_i(op_imm, 3'b000, 5'd0, 5'd1, 12'd5), 1'b1, 5'd0, xr[1] + 32'd5);
        emit(enc_u(op_lui, 5'd16, 20'h12345), 1'b1, 5'd16, {20'h12345, 12'h000});
        here = prog_addr();
        emit(enc_u(op_auipc, 5'd17, 20'h00001), 1'b1, 5'd17, here + {20'h00001, 12'h000});
        // sw then sb into byte 1 of the same word
        emit(enc_s(3'b010, 5'd0, 5'd16, 12'd16), 1'b0, 5'd0, '0);
        add_store(32'd16, xr[16], 4'b1111);
        word = xr[16];
        emit(enc_s(3'b000, 5'd0, 5'd1, 12'd17), 1'b0, 5'd0, '0);
        add_store(32'd17, {16'h0, xr[1][7:0], 8'h0}, 4'b0010);
        word[15:8] = xr[1][7:0];
        emit(enc_i(op_load, 3'b010, 5'd19, 5'd0, 12'd16), 1'b1, 5'd19, word);
        emit(enc_i(op_load, 3'b100, 5'd20, 5'd0, 12'd19), 1'b1, 5'd20, {24'h0, word[31:24]});
        emit(enc_i(op_load, 3'b100, 5'd21, 5'd0, 12'd17), 1'b1, 5'd21, {24'h0, word[15:8]});
        // x16 is nonzero so this bne skips one word
        emit(enc_b(3'b001, 5'd16, 5'd0, 13'd8), 1'b0, 5'd0, '0);
        skip(enc_i(op_imm, 3'b000, 5'd22, 5'd0, 12'd1));
        // equal operands, falls through
        emit(enc_b(3'b001, 5'd1, 5'd1, 13'd8), 1'b0, 5'd0, '0);
        emit(enc_i(op_imm, 3'b000, 5'd22, 5'd0, 12'd11), 1'b1, 5'd22, 32'd11);
        here = prog_addr();
        emit(enc_j(5'd23, 21'd12), 1'b1, 5'd23, here + 32'd4);
        skip(enc_i(op_imm, 3'b000, 5'd24, 5'd0, 12'd2));
        skip(enc_i(op_imm, 3'b000, 5'd24, 5'd0, 12'd3));
        // jalr lands 16 bytes past the auipc
        here = prog_addr();
        emit(enc_u(op_auipc, 5'd25, 20'h00000), 1'b1, 5'd25, here);
        emit(enc_i(op_jalr, 3'b000, 5'd26, 5'd25, 12'd16), 1'b1, 5'd26, here + 32'd8);
        skip(enc_i(op_imm, 3'b000, 5'd27, 5'd0, 12'd4));
        skip(enc_i(op_imm, 3'b000, 5'd27, 5'd0, 12'd5));
        emit(enc_i(op_imm, 3'b000, 5'd28, 5'd0, 12'h07f), 1'b1, 5'd28, 32'h7f);
        emit(ebreak_word, 1'b0, 5'd0, '0);
    endtask

    // next store trace against the store table
    task automatic check_store();
        if (store_en) begin
            assert (n_seen < n_store) else begin
                $display("unexpected store at pc %h", pc);
                errors++;
            end
            if (n_seen < n_store) begin
                checks++;
                assert (store_addr == st_addr[n_seen]) else begin
                    $display("ERR store_addr got %h exp %h", store_addr, st_addr[n_seen]);
                    errors++;
                end
                assert (store_data == st_data[n_seen]) else begin
                    $display("ERR store_data got %h exp %h", store_data, st_data[n_seen]);
                    errors++;
                end
                assert (store_mask == st_mask[n_seen]) else begin
                    $display("ERR store_mask got %h exp %h", store_mask, st_mask[n_seen]);
                    errors++;
                end
                n_seen++;
            end
        end
    endtask

    task automatic check_cycle(input int k);
        checks++;
        assert (pc == exp_pc[k]) else begin
            $display("ERR pc got %h exp %h", pc, exp_pc[k]);
            errors++;
        end
        assert (!halted) else begin
            $display("halted is high before ebreak, cycle %0d", k);
            errors++;
        end
        assert (retire_en == exp_en[k]) else begin
            $display("ERR retire_en got %h exp %h at pc %h", retire_en, exp_en[k], pc);
            errors++;
        end
        if (exp_en[k] && retire_en) begin
            assert (retire_rd == exp_rd[k]) else begin
                $display("ERR retire_rd got %h exp %h", retire_rd, exp_rd[k]);
                errors++;
            end
            assert (retire_data == exp_val[k]) else begin
                $display("ERR retire_data got %h exp %h", retire_data, exp_val[k]);
                errors++;
            end
        end
        check_store();
    endtask

    // pc sits on the ebreak, nothing commits
    task automatic check_halt();
        checks++;
        assert (halted) else begin
            $display("halted did not rise after ebreak");
            errors++;
        end
        assert (pc == exp_pc[n_cyc - 1]) else begin
            $display("ERR pc got %h exp %h", pc, exp_pc[n_cyc - 1]);
            errors++;
        end
        assert (!retire_en) else begin
            $display("register write to x%0d after halt", retire_rd);
            errors++;
        end
        check_store();
    endtask

    initial begin
        int i;
        clk          = 1'b0;
        reset        = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        errors       = 0;
        checks       = 0;
        n_seen       = 0;
        tables_ready = 1'b0;
        build_program();
        tables_ready = 1'b1;
        // load the program while the core is held in reset
        for (i = 0; i < n_prog; i++) begin
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = imem_addr_t'(i);
            load_data = prog[i];
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
        repeat (reset_cycles - 1) @(posedge clk);
        #1;
        reset = 1'b0;
        // outputs sampled at the falling edge
        for (i = 0; i < n_cyc; i++) begin
            @(negedge clk);
            check_cycle(i);
        end
        for (i = 0; i < halt_cycles; i++) begin
            @(negedge clk);
            check_halt();
        end
        assert (n_seen == n_store) else begin
            $display("only %0d of %0d expected stores were seen", n_seen, n_store);
            errors++;
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // limit from load, reset, run and halt lengths plus margin
    initial begin
        wait (tables_ready);
        #((n_prog + reset_cycles + n_cyc + halt_cycles + 20) * 4);
        $display("watchdog expired before the test sequence finished");
        $display("checks %0d errors %0d", checks, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* npc.sv */
`timescale 1ns/1ps
`default_nettype none

module npc
    import npc_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  inst_t      load_data,
    output xlen_t      pc,
    output logic       halted,
    output logic       retire_en,
    output reg_idx_t   retire_rd,
    output xlen_t      retire_data,
    output logic       store_en,
    output xlen_t      store_addr,
    output xlen_t      store_data,
    output logic [3:0] store_mask
);

    inst_t      inst;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    xlen_t      imm;
    alu_op_t    alu_op;
    logic       src1_is_pc;
    logic       src2_is_imm;
    logic       reg_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic       byte_access;
    logic       is_jal;
    logic       is_jalr;
    logic       is_bne;
    logic       is_ebreak;
    logic [1:0] wb_sel;
    xlen_t      rdata1;
    xlen_t      rdata2;
    xlen_t      alu_result;
    logic       wb_en;
    xlen_t      wb_data;

    // pc, instruction memory and halt state
    npc_fetch u_fetch (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .rdata1(rdata1), .imm(imm), .alu_result(alu_result),
        .is_jal(is_jal), .is_jalr(is_jalr), .is_bne(is_bne), .is_ebreak(is_ebreak),
        .pc(pc), .inst(inst), .halted(halted)
    );

    npc_decode u_decode (
        .inst(inst), .reset(reset), .halted(halted), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .alu_op(alu_op), .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm),
        .reg_wen(reg_wen), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .byte_access(byte_access), .is_jal(is_jal), .is_jalr(is_jalr),
        .is_bne(is_bne), .is_ebreak(is_ebreak), .wb_sel(wb_sel)
    );

    // written from the lsu writeback select
    npc_regfile u_regfile (
        .clk(clk), .we(wb_en), .waddr(rd), .raddr1(rs1), .raddr2(rs2),
        .wdata(wb_data), .rdata1(rdata1), .rdata2(rdata2)
    );

    npc_alu u_alu (
        .pc(pc), .rdata1(rdata1), .rdata2(rdata2), .imm(imm), .src1_is_pc(src1_is_pc),
        .src2_is_imm(src2_is_imm), .alu_op(alu_op), .alu_result(alu_result)
    );

    // data memory and writeback value
    npc_lsu u_lsu (
        .clk(clk), .mem_ren(mem_ren), .mem_wen(mem_wen), .byte_access(byte_access),
        .reg_wen(reg_wen), .wb_sel(wb_sel), .rd(rd), .alu_result(alu_result),
        .rdata2(rdata2), .pc(pc), .imm(imm), .wb_en(wb_en), .wb_data(wb_data),
        .store_en(store_en), .store_addr(store_addr), .store_data(store_data),
        .store_mask(store_mask)
    );

    // retire trace is the register write itself
    assign retire_en   = wb_en;
    assign retire_rd   = rd;
    assign retire_data = wb_data;

endmodule

`default_nettype wire

/* npc_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module npc_lsu
    import npc_pkg::*;
(
    input  logic       clk,
    input  logic       mem_ren,
    input  logic       mem_wen,
    input  logic       byte_access,
    input  logic       reg_wen,
    input  logic [1:0] wb_sel,
    input  reg_idx_t   rd,
    input  xlen_t      alu_result,
    input  xlen_t      rdata2,
    input  xlen_t      pc,
    input  xlen_t      imm,
    output logic       wb_en,
    output xlen_t      wb_data,
    output logic       store_en,
    output xlen_t      store_addr,
    output xlen_t      store_data,
    output logic [3:0] store_mask
);

    xlen_t      dmem [dmem_words];
    dmem_addr_t word_idx;
    logic [1:0] lane;
    xlen_t      mem_word;
    logic [7:0] mem_byte;
    xlen_t      load_data;

    // word index from address, low bits pick the byte lane
    assign word_idx = alu_result[$bits(dmem_addr_t)+1:2];
    assign lane     = alu_result[1:0];

    // store trace, byte moved into its lane
    assign store_en   = mem_wen;
    assign store_addr = alu_result;
    assign store_data = byte_access ? (xlen_t'(rdata2[7:0]) << {lane, 3'b000}) : rdata2;
    assign store_mask = byte_access ? (4'b0001 << lane) : 4'b1111;

    // byte-masked write
    always_ff @(posedge clk) begin
        if (mem_wen) begin
            for (int i = 0; i < 4; i++) begin
                if (store_mask[i]) begin
                    dmem[word_idx][8*i +: 8] <= store_data[8*i +: 8];
                end
            end
        end
    end

    // combinational load, lbu zero-extends
    assign mem_word  = dmem[word_idx];
    assign mem_byte  = mem_word[{lane, 3'b000} +: 8];
    assign load_data = !mem_ren    ? '0 :
                       byte_access ? {24'b0, mem_byte} : mem_word;

    always_comb begin
        case (wb_sel)
            wb_mem:  wb_data = load_data;
            wb_pc4:  wb_data = pc + xlen_t'(4);
            wb_imm:  wb_data = imm;
            default: wb_data = alu_result;
        endcase
    end

    // x0 writes never show up as retires
    assign wb_en = reg_wen && (rd != '0);

    // misaligned word access is not handled, so base plus offset must be aligned
    word_aligned: assert property (@(posedge clk)
        ((mem_ren || mem_wen) && !byte_access) |-> (alu_result[1:0] == 2'b00));

endmodule

`default_nettype wire

/* npc_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module npc_alu
    import npc_pkg::*;
(
    input  xlen_t   pc,
    input  xlen_t   rdata1,
    input  xlen_t   rdata2,
    input  xlen_t   imm,
    input  logic    src1_is_pc,
    input  logic    src2_is_imm,
    input  alu_op_t alu_op,
    output xlen_t   alu_result
);

    xlen_t op1;
    xlen_t op2;

    // pc only for auipc
    assign op1 = src1_is_pc ? pc : rdata1;
    // immediate for i-type, loads, stores, auipc
    assign op2 = src2_is_imm ? imm : rdata2;

    always_comb begin
        case (alu_op)
            alu_add:  alu_result = op1 + op2;
            alu_sub:  alu_result = op1 - op2;
            // sltu and sltiu, unsigned compare
            alu_sltu: alu_result = {31'b0, op1 < op2};
            alu_xor:  alu_result = op1 ^ op2;
            alu_or:   alu_result = op1 | op2;
            // shift amount from low five bits
            alu_sra:  alu_result = xlen_t'($signed(op1) >>> op2[4:0]);
            // branch flag, 1 when operands differ
            alu_ne:   alu_result = {31'b0, op1 != op2};
            default:  alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* npc_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module npc_regfile
    import npc_pkg::*;
(
    input  logic     clk,
    input  logic     we,
    input  reg_idx_t waddr,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  xlen_t    wdata,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    // x0 entry exists but is never written or read
    xlen_t regs [32];

    // write lands at the edge
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* npc_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module npc_decode
    import npc_pkg::*;
(
    input  inst_t      inst,
    input  logic       reset,
    input  logic       halted,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output reg_idx_t   rd,
    output xlen_t      imm,
    output alu_op_t    alu_op,
    output logic       src1_is_pc,
    output logic       src2_is_imm,
    output logic       reg_wen,
    output logic       mem_ren,
    output logic       mem_wen,
    output logic       byte_access,
    output logic       is_jal,
    output logic       is_jalr,
    output logic       is_bne,
    output logic       is_ebreak,
    output logic [1:0] wb_sel
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    // all formats sign extend from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        imm         = '0;
        alu_op      = alu_add;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        reg_wen     = 1'b0;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        byte_access = 1'b0;
        is_jal      = 1'b0;
        is_jalr     = 1'b0;
        is_bne      = 1'b0;
        is_ebreak   = 1'b0;
        wb_sel      = wb_alu;
        case (opcode)
            op_lui: begin
                imm     = imm_u;
                reg_wen = 1'b1;
                wb_sel  = wb_imm;
            end
            op_auipc: begin
                // pc plus upper immediate through the alu
                imm         = imm_u;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                reg_wen     = 1'b1;
            end
            op_jal: begin
                imm     = imm_j;
                is_jal  = 1'b1;
                reg_wen = 1'b1;
                wb_sel  = wb_pc4;
            end
            op_jalr: begin
                imm         = imm_i;
                src2_is_imm = 1'b1;
                is_jalr     = (funct3 == 3'b000);
                reg_wen     = is_jalr;
                wb_sel      = wb_pc4;
            end
            op_branch: begin
                // only bne, alu flags the inequality
                imm    = imm_b;
                is_bne = (funct3 == 3'b001);
                alu_op = alu_ne;
            end
            op_load: begin
                // address is rs1 plus imm, lw or lbu
                imm         = imm_i;
                src2_is_imm = 1'b1;
                mem_ren     = (funct3 == 3'b010) || (funct3 == 3'b100);
                byte_access = (funct3 == 3'b100);
                reg_wen     = mem_ren;
                wb_sel      = wb_mem;
            end
            op_store: begin
                // sw or sb
                imm         = imm_s;
                src2_is_imm = 1'b1;
                mem_wen     = (funct3 == 3'b010) || (funct3 == 3'b000);
                byte_access = (funct3 == 3'b000);
            end
            op_imm: begin
                imm         = imm_i;
                src2_is_imm = 1'b1;
                case (funct3)
                    3'b000: reg_wen = 1'b1;
                    3'b011: begin
                        alu_op  = alu_sltu;
                        reg_wen = 1'b1;
                    end
                    3'b101: begin
                        // srai only, srli not in subset
                        alu_op  = alu_sra;
                        reg_wen = (funct7 == 7'b0100000);
                    end
                    default: reg_wen = 1'b0;
                endcase
            end
            op_reg: begin
                case (funct3)
                    3'b000: begin
                        alu_op  = funct7[5] ? alu_sub : alu_add;
                        reg_wen = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                    3'b011: begin
                        alu_op  = alu_sltu;
                        reg_wen = (funct7 == 7'b0000000);
                    end
                    3'b100: begin
                        alu_op  = alu_xor;
                        reg_wen = (funct7 == 7'b0000000);
                    end
                    3'b110: begin
                        alu_op  = alu_or;
                        reg_wen = (funct7 == 7'b0000000);
                    end
                    default: reg_wen = 1'b0;
                endcase
            end
            op_system: is_ebreak = (inst == ebreak_word);
            default: ;
        endcase
        // nothing commits during reset or after halt
        if (reset || halted) begin
            reg_wen   = 1'b0;
            mem_ren   = 1'b0;
            mem_wen   = 1'b0;
            is_jal    = 1'b0;
            is_jalr   = 1'b0;
            is_bne    = 1'b0;
            is_ebreak = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* npc_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module npc_fetch
    import npc_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  inst_t      load_data,
    input  xlen_t      rdata1,
    input  xlen_t      imm,
    input  xlen_t      alu_result,
    input  logic       is_jal,
    input  logic       is_jalr,
    input  logic       is_bne,
    input  logic       is_ebreak,
    output xlen_t      pc,
    output inst_t      inst,
    output logic       halted
);

    inst_t      imem [imem_words];
    npc_state_t state;
    xlen_t      pc_off;
    imem_addr_t fetch_idx;
    xlen_t      next_pc;

    // byte offset of pc into instruction memory
    assign pc_off    = pc - reset_vector;
    assign fetch_idx = pc_off[$bits(imem_addr_t)+1:2];
    assign halted    = (state == st_halt);

    // combinational read, nop once halted so nothing writes
    assign inst = halted ? nop_word : imem[fetch_idx];

    // jalr target has bit 0 cleared
    always_comb begin
        if (is_jalr) begin
            next_pc = (rdata1 + imm) & ~xlen_t'(1);
        end else if (is_jal || (is_bne && alu_result[0])) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + xlen_t'(4);
        end
    end

    // load port, host fills memory while reset is held
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    // pc freezes on ebreak and stays there
    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= reset_vector;
            state <= st_run;
        end else if (state == st_run) begin
            if (is_ebreak) begin
                state <= st_halt;
            end else begin
                pc <= next_pc;
            end
        end
    end

    // jump targets from decode and alu must keep word alignment
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

    // running core never leaves the loaded program
    pc_in_imem: assert property (@(posedge clk) disable iff (reset)
        (state == st_run) |-> (pc_off < xlen_t'(imem_words * 4)));

endmodule

`default_nettype wire

/* npc_pkg.sv */
`default_nettype none

package npc_pkg;

    // data and address word
    typedef logic [31:0] xlen_t;
    // raw instruction word
    typedef logic [31:0] inst_t;
    // architectural register index
    typedef logic [4:0] reg_idx_t;
    // alu operation select
    typedef logic [3:0] alu_op_t;

    // first fetch address after reset
    localparam xlen_t reset_vector = 32'h8000_0000;

    // memory depths in words
    localparam int imem_words = 256;
    localparam int dmem_words = 256;

    // word indices into the two memories
    typedef logic [7:0] imem_addr_t;
    typedef logic [7:0] dmem_addr_t;

    // major opcodes of the supported subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    // alu operations
    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_sltu = 4'd2;
    localparam alu_op_t alu_xor  = 4'd3;
    localparam alu_op_t alu_or   = 4'd4;
    localparam alu_op_t alu_sra  = 4'd5;
    // result is 1 when operands differ, used by bne
    localparam alu_op_t alu_ne   = 4'd6;

    // writeback source select
    localparam logic [1:0] wb_alu = 2'd0;
    localparam logic [1:0] wb_mem = 2'd1;
    localparam logic [1:0] wb_pc4 = 2'd2;
    localparam logic [1:0] wb_imm = 2'd3;

    // run/halt machine in fetch
    typedef enum logic {
        st_run,
        st_halt
    } npc_state_t;

    localparam inst_t ebreak_word = 32'h0010_0073;
    // addi x0, x0, 0
    localparam inst_t nop_word    = 32'h0000_0013;

endpackage

`default_nettype wire
